// File: common/motion_pkg.sv
package motion_pkg;

  // Host command codes, carried in the top byte of a header word
  typedef enum logic [7:0] {
    CMD_MOVE      = 8'h01,
    CMD_ENABLE    = 8'h02,
    CMD_DIVISOR   = 8'h03,
    CMD_STEP_MODE = 8'h04,
    CMD_VERSION   = 8'hFE
  } cmd_e;

  localparam logic [7:0] VERSION_MAJOR = 8'd1;
  localparam logic [7:0] VERSION_MINOR = 8'd2;
  localparam logic [7:0] VERSION_PATCH = 8'd3;

  // Reply to CMD_VERSION, major in the top byte of the low 24 bits
  localparam logic [63:0] VERSION_WORD = {40'd0, VERSION_MAJOR, VERSION_MINOR, VERSION_PATCH};

  // Accumulator value worth one full step
  localparam logic signed [63:0] STEP_THRESHOLD = 64'sh0000_0001_0000_0000;

  localparam logic [7:0] DEFAULT_DIVISOR = 8'd40;

  typedef struct packed {
    cmd_e        cmd;
    logic [55:0] payload;  // Bit 0 dir/enable/mode, bits 7:0 divisor
  } header_t;

  // One received SPI word, either a header or a raw data word
  typedef union packed {
    header_t     hdr;
    logic [63:0] raw;
  } spi_word_u;

  typedef struct packed {
    logic               dir;
    logic [31:0]        duration;   // Ticks
    logic signed [63:0] increment;
    logic signed [63:0] accel;      // Added to increment every tick
  } move_t;

  typedef struct packed {
    logic       enable;
    logic [7:0] divisor;
    logic       half_step;
  } motion_cfg_t;

endpackage

// File: spi/spi_word_port.sv
`timescale 1ns/1ps

module spi_word_port import motion_pkg::*; (
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        sck,
  input  logic        cs,
  input  logic        copi,
  output logic        cipo,
  input  logic [63:0] reply,
  output spi_word_u   word,
  output logic        word_valid
);

  logic [2:0]  sck_sync;
  logic [2:0]  cs_sync;
  logic [1:0]  copi_sync;
  logic [6:0]  bit_cnt;
  logic [63:0] tx_shift;

  // Edge detection on the synchronized copies
  wire sck_rise  = sck_sync[1] & ~sck_sync[2];
  wire sck_fall  = ~sck_sync[1] & sck_sync[2];
  wire cs_fall   = ~cs_sync[1] & cs_sync[2];
  wire cs_rise   = cs_sync[1] & ~cs_sync[2];
  wire cs_active = ~cs_sync[1];

  assign cipo = tx_shift[63];  // MSB first

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync   <= 3'b000;
      cs_sync    <= 3'b111;  // CS idles high
      copi_sync  <= 2'b00;
      bit_cnt    <= '0;
      tx_shift   <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_sync   <= {sck_sync[1:0], sck};
      cs_sync    <= {cs_sync[1:0], cs};
      copi_sync  <= {copi_sync[0], copi};
      word_valid <= cs_rise && (bit_cnt == 7'd64);

      if (cs_fall) begin
        bit_cnt  <= '0;
        tx_shift <= reply;  // Reply latched at the end of the previous frame
      end else if (cs_active) begin
        if (sck_rise && bit_cnt != 7'h7f) begin
          bit_cnt <= bit_cnt + 7'd1;  // Saturates so long frames are rejected
        end
        if (sck_fall) begin
          tx_shift <= {tx_shift[62:0], 1'b0};
        end
      end
    end
  end

  // Receive shifter, read only on word_valid
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      word.raw <= {word.raw[62:0], copi_sync[1]};
    end
  end

endmodule

// File: verilog/command_sequencer.sv
`timescale 1ns/1ps

module command_sequencer import motion_pkg::*; (
  input  logic               CLK,
  input  logic               rst_n,
  input  spi_word_u          word,
  input  logic               word_valid,
  output logic [63:0]        reply,
  input  logic signed [63:0] enc_count,
  output motion_cfg_t        cfg,
  output move_t              push_move,
  output logic               push,
  input  logic               full
);

  typedef enum logic [1:0] {
    IDLE,
    MOVE_DUR,
    MOVE_INC,
    MOVE_ACC
  } state_e;

  state_e             state;
  logic signed [63:0] enc_snap;  // Encoder count at the move header

  wire is_move_hdr = (state == IDLE) && (word.hdr.cmd == CMD_MOVE);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state         <= IDLE;
      cfg.enable    <= 1'b0;
      cfg.divisor   <= DEFAULT_DIVISOR;
      cfg.half_step <= 1'b0;
      reply         <= '0;
      push          <= 1'b0;
    end else begin
      push <= 1'b0;
      if (word_valid) begin
        reply <= '0;
        case (state)
          IDLE: begin
            case (word.hdr.cmd)
              CMD_MOVE:      state <= MOVE_DUR;
              CMD_ENABLE:    cfg.enable <= word.hdr.payload[0];
              CMD_DIVISOR:   cfg.divisor <= word.hdr.payload[7:0];
              CMD_STEP_MODE: cfg.half_step <= word.hdr.payload[0];
              CMD_VERSION:   reply <= VERSION_WORD;
              default:       ;  // Unknown codes are ignored
            endcase
          end
          MOVE_DUR: state <= MOVE_INC;
          MOVE_INC: begin
            reply <= enc_snap;  // Host reads it back during the accel frame
            state <= MOVE_ACC;
          end
          MOVE_ACC: begin
            push  <= ~full;  // Dropped when the queue has no room
            state <= IDLE;
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Move record assembly
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (is_move_hdr) begin
        push_move.dir <= word.hdr.payload[0];
        enc_snap      <= enc_count;
      end
      if (state == MOVE_DUR) push_move.duration <= word.raw[31:0];
      if (state == MOVE_INC) push_move.increment <= signed'(word.raw);
      if (state == MOVE_ACC) push_move.accel <= signed'(word.raw);
    end
  end

endmodule

// File: verilog/move_queue.sv
`timescale 1ns/1ps

module move_queue import motion_pkg::*; #(
  parameter int QUEUE_DEPTH = 4  // Power of two, at least 2
) (
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  push,
  input  move_t push_move,
  input  logic  pop,
  output move_t head,
  output logic  full,
  output logic  empty
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  move_t             mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [PTR_W:0]    count;

  wire do_push = push & ~full;
  wire do_pop  = pop & ~empty;

  assign full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
  assign empty = (count == '0);
  assign head  = mem[rd_ptr];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap on their own
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)      count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) mem[wr_ptr] <= push_move;
  end

endmodule

// File: dda/tick_divider.sv
`timescale 1ns/1ps

module tick_divider (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic [7:0] divisor,
  output logic       tick
);

  logic [7:0] cnt;

  // Free running, one tick every divisor+1 clocks
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else if (cnt == 8'd0) begin
      cnt  <= divisor;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 8'd1;
      tick <= 1'b0;
    end
  end

endmodule

// File: dda/dda_step_engine.sv
`timescale 1ns/1ps

module dda_step_engine import motion_pkg::*; (
  input  logic  CLK,
  input  logic  rst_n,
  input  logic  tick,
  input  move_t head,
  input  logic  empty,
  output logic  pop,
  output logic  step,
  output logic  dir,
  output logic  busy
);

  logic [31:0]        remaining;  // Ticks left in the running move
  logic signed [63:0] incr;
  logic signed [63:0] accel;
  logic signed [63:0] accum;

  wire signed [63:0] accum_sum = accum + incr;

  assign pop = ~busy & ~empty;  // Load the head record in the same cycle

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      remaining <= '0;
      accum     <= '0;
      step      <= 1'b0;
      dir       <= 1'b0;
    end else begin
      step <= 1'b0;
      if (pop) begin
        busy      <= (head.duration != 32'd0);
        remaining <= head.duration;
        dir       <= head.dir;
      end else if (busy && tick) begin
        if (accum_sum >= STEP_THRESHOLD) begin
          accum <= accum_sum - STEP_THRESHOLD;
          step  <= 1'b1;  // At most one step per tick
        end else begin
          accum <= accum_sum;
        end
        remaining <= remaining - 32'd1;
        if (remaining == 32'd1) busy <= 1'b0;  // Last tick of the move
      end
    end
  end

  // Velocity registers, loaded from every popped record
  always_ff @(posedge CLK) begin
    if (pop) begin
      incr  <= head.increment;
      accel <= head.accel;
    end else if (busy && tick) begin
      incr <= incr + accel;
    end
  end

endmodule

// File: verilog/quad_decoder.sv
`timescale 1ns/1ps

module quad_decoder (
  input  logic               CLK,
  input  logic               rst_n,
  input  logic               a,
  input  logic               b,
  output logic signed [63:0] count
);

  logic [1:0] ab_meta;
  logic [1:0] ab_sync;
  logic [1:0] ab_prev;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ab_meta <= 2'b00;
      ab_sync <= 2'b00;
      ab_prev <= 2'b00;
      count   <= '0;
    end else begin
      ab_meta <= {a, b};
      ab_sync <= ab_meta;
      ab_prev <= ab_sync;
      // Transition table on {previous AB, current AB}
      case ({ab_prev, ab_sync})
        4'b0010, 4'b1011, 4'b1101, 4'b0100: count <= count + 64'sd1;  // A leads
        4'b0001, 4'b0111, 4'b1110, 4'b1000: count <= count - 64'sd1;  // B leads
        default: ;  // No change or a skipped state
      endcase
    end
  end

endmodule

// File: verilog/hbridge_phaser.sv
`timescale 1ns/1ps

module hbridge_phaser (
  input  logic CLK,
  input  logic rst_n,
  input  logic step,
  input  logic dir,
  input  logic enable,
  input  logic half_step,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  logic [2:0] pos;  // Index into the eight entry half step table
  logic [3:0] coils;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pos <= '0;
    end else if (step) begin
      if (half_step) pos <= dir ? pos + 3'd1 : pos - 3'd1;
      else           pos <= {dir ? pos[2:1] + 2'd1 : pos[2:1] - 2'd1, 1'b0};  // Stay even
    end
  end

  // Coil order a1 a2 b1 b2
  always_comb begin
    case (pos)
      3'd0: coils = 4'b1000;
      3'd1: coils = 4'b1010;
      3'd2: coils = 4'b0010;
      3'd3: coils = 4'b0110;
      3'd4: coils = 4'b0100;
      3'd5: coils = 4'b0101;
      3'd6: coils = 4'b0001;
      default: coils = 4'b1001;
    endcase
  end

  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? coils : 4'b0000;

endmodule

// File: verilog/motion_top.sv
`timescale 1ns/1ps

module motion_top import motion_pkg::*; #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic CLK,
  input  logic rst_n,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic buffer_ready
);

  spi_word_u          word;
  logic               word_valid;
  logic [63:0]        reply;
  logic signed [63:0] enc_count;
  motion_cfg_t        cfg;
  move_t              push_move;
  move_t              head;
  logic               push, pop, full, empty;
  logic               tick, step, dir;

  assign buffer_ready = ~full;

  spi_word_port u_spi (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .cs(cs), .copi(copi), .cipo(cipo),
    .reply(reply), .word(word), .word_valid(word_valid)
  );

  command_sequencer u_seq (
    .CLK(CLK), .rst_n(rst_n), .word(word), .word_valid(word_valid), .reply(reply),
    .enc_count(enc_count), .cfg(cfg), .push_move(push_move), .push(push), .full(full)
  );

  move_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
    .CLK(CLK), .rst_n(rst_n), .push(push), .push_move(push_move), .pop(pop),
    .head(head), .full(full), .empty(empty)
  );

  tick_divider u_div (.CLK(CLK), .rst_n(rst_n), .divisor(cfg.divisor), .tick(tick));

  dda_step_engine u_dda (
    .CLK(CLK), .rst_n(rst_n), .tick(tick), .head(head), .empty(empty), .pop(pop),
    .step(step), .dir(dir), .busy()
  );

  quad_decoder u_enc (.CLK(CLK), .rst_n(rst_n), .a(enc_a), .b(enc_b), .count(enc_count));

  hbridge_phaser u_phase (
    .CLK(CLK), .rst_n(rst_n), .step(step), .dir(dir), .enable(cfg.enable),
    .half_step(cfg.half_step), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2)
  );

endmodule

// File: verification/motion_checker.sv
`timescale 1ns/1ps

module motion_checker (
  input logic CLK,
  input logic rst_n,
  input logic push,
  input logic full,
  input logic step
);

  // Queue handshake between the parser and the move queue
  push_not_full: assert property (@(posedge CLK) disable iff (!rst_n) !(push && full))
    else $error("push while queue full");
  push_single: assert property (@(posedge CLK) disable iff (!rst_n) push |=> !push)
    else $error("push high on two consecutive cycles");

  // Step pulses are spaced by the tick divider
  step_single: assert property (@(posedge CLK) disable iff (!rst_n) step |=> !step)
    else $error("step high on two consecutive cycles");

endmodule

bind motion_top motion_checker u_chk (
  .CLK(CLK), .rst_n(rst_n), .push(push), .full(full), .step(step)
);

// File: verification/motion_tb.sv
`timescale 1ns/1ps

module motion_tb import motion_pkg::*; ();

  localparam int QUEUE_DEPTH = 4;

  logic CLK = 1'b0;
  logic rst_n, sck, cs, copi, enc_a, enc_b;
  logic cipo, phase_a1, phase_a2, phase_b1, phase_b2, buffer_ready;

  logic [31:0] lfsr = 32'h44abb2e1;
  logic [1:0]  gray [4] = '{2'b00, 2'b10, 2'b11, 2'b01};  // A leads going up
  int          enc_idx = 0;
  longint      model_acc = 0;  // Reference accumulator
  longint      exp_pos = 0;
  int          step_pos = 0;
  int          hpos = 0;       // Half step positions seen on the coils
  int          last_idx = 0;
  bit          half_mode = 1'b0;

  motion_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) UUT (
    .CLK(CLK), .rst_n(rst_n), .sck(sck), .cs(cs), .copi(copi), .enc_a(enc_a),
    .enc_b(enc_b), .cipo(cipo), .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2), .buffer_ready(buffer_ready)
  );

  always #4 CLK = ~CLK;

  function automatic int coil_index(input logic [3:0] c);
    case (c)
      4'b1000: return 0;
      4'b1010: return 1;
      4'b0010: return 2;
      4'b0110: return 3;
      4'b0100: return 4;
      4'b0101: return 5;
      4'b0001: return 6;
      4'b1001: return 7;
      default: return -1;  // Coils off
    endcase
  endfunction

  // Phase tracker, keeps the last index while the coils are off
  always @(posedge CLK) begin : phase_monitor
    int idx;
    int d;
    idx = coil_index({phase_a1, phase_a2, phase_b1, phase_b2});
    if (idx >= 0) begin
      d = (idx - last_idx + 8) % 8;
      if (d > 4) d = d - 8;
      step_pos += half_mode ? d : d / 2;
      hpos += d;
      last_idx = idx;
    end
  end

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
      fail_now($sformatf("error at %0t: %s expected %0h, got %0h", $time, name, exp, act));
  endtask

  task automatic cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // One 64 bit frame, SCK at CLK/16
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    int n;
    n = 0;
    cs = 1'b0;
    cycles(8);
    for (int i = 63; i >= 0; i--) begin
      copi = tx[i];
      cycles(8);
      rx[i] = cipo;
      sck = 1'b1;
      cycles(8);
      sck = 1'b0;
    end
    cycles(8);
    cs = 1'b1;
    while (!UUT.u_spi.word_valid) begin
      if (n++ > 20) fail_now("word_valid never pulsed after the frame");
      cycles(1);
    end
    cycles(4);
  endtask

  task automatic send_cmd(input cmd_e cmd, input logic [55:0] payload);
    logic [63:0] r;
    spi_xfer({cmd, payload}, r);
  endtask

  task automatic send_move(input bit dir, input logic [31:0] dur, input longint inc,
                           input longint acc, output logic [63:0] snap);
    logic [63:0] r;
    spi_xfer({CMD_MOVE, 55'd0, dir}, r);
    spi_xfer({32'd0, dur}, r);
    spi_xfer(inc, r);
    spi_xfer(acc, snap);  // Reply carries the encoder snapshot
    cycles(3);
  endtask

  // Reference DDA, one step at most per tick
  task automatic run_model(input bit dir, input logic [31:0] dur, input longint inc,
                           input longint acc, input bit track);
    longint steps;
    steps = 0;
    for (int unsigned k = 0; k < dur; k++) begin
      model_acc += inc;
      inc += acc;
      if (model_acc >= STEP_THRESHOLD) begin
        model_acc -= STEP_THRESHOLD;
        steps++;
      end
    end
    if (track) exp_pos += dir ? steps : -steps;
  endtask

  task automatic wait_idle(input int limit, input bit coils_off);
    int n;
    n = 0;
    while (!(UUT.u_queue.empty && !UUT.u_dda.busy)) begin
      if (coils_off && {phase_a1, phase_a2, phase_b1, phase_b2} != 4'b0000)
        fail_now("coils driven while the motor is disabled");
      if (n++ > limit) fail_now("timeout waiting for the move queue to drain");
      cycles(1);
    end
    cycles(4);
  endtask

  task automatic drive_encoder(input int edges, input bit up);
    repeat (edges) begin
      enc_idx = up ? (enc_idx + 1) % 4 : (enc_idx + 3) % 4;
      {enc_a, enc_b} = gray[enc_idx];
      cycles(6);
    end
  endtask

  task automatic version_after_reset();
    logic [63:0] r;
    check_value("coils", 64'd0, 64'({phase_a1, phase_a2, phase_b1, phase_b2}));
    check_value("buffer_ready", 64'd1, 64'(buffer_ready));
    send_cmd(CMD_VERSION, 56'd0);
    spi_xfer(64'd0, r);
    check_value("version", 64'h010203, {40'd0, r[23:0]});
  endtask

  task automatic constant_velocity_moves();
    bit          dir;
    logic [31:0] dur;
    longint      inc;
    logic [63:0] snap;
    send_cmd(CMD_ENABLE, 56'd1);
    repeat (3) begin
      dir = rand_bits(1) != 0;
      dur = 32'd16 + 32'(rand_bits(5));
      inc = longint'(rand_bits(31));
      send_move(dir, dur, inc, 0, snap);
      run_model(dir, dur, inc, 0, 1'b1);
    end
    wait_idle(20000, 1'b0);
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  task automatic accel_move();
    logic [63:0] snap;
    send_move(1'b1, 32'd16, 0, STEP_THRESHOLD / 8, snap);
    run_model(1'b1, 32'd16, 0, STEP_THRESHOLD / 8, 1'b1);
    wait_idle(2000, 1'b0);
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  task automatic encoder_snapshot();
    logic [63:0] snap;
    drive_encoder(37, 1'b1);
    drive_encoder(5, 1'b0);
    cycles(8);
    send_move(1'b0, 32'd0, 0, 0, snap);
    check_value("encoder snapshot", 64'd32, snap);
  endtask

  task automatic disabled_coils();
    logic [63:0] snap;
    send_cmd(CMD_ENABLE, 56'd0);
    // 16 full steps bring the table index back where it was
    send_move(1'b1, 32'd16, STEP_THRESHOLD, 0, snap);
    run_model(1'b1, 32'd16, STEP_THRESHOLD, 0, 1'b0);
    wait_idle(2000, 1'b1);
    send_cmd(CMD_ENABLE, 56'd1);
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  task automatic queue_backpressure();
    logic [63:0] snap;
    send_cmd(CMD_DIVISOR, 56'd255);
    for (int i = 0; i <= QUEUE_DEPTH + 1; i++) begin
      send_move(1'b1, 32'd200, 64'sd1 <<< 28, 0, snap);
      if (i <= QUEUE_DEPTH) run_model(1'b1, 32'd200, 64'sd1 <<< 28, 0, 1'b1);
      if (i == QUEUE_DEPTH) check_value("buffer_ready", 64'd0, 64'(buffer_ready));
    end
    wait_idle(300000, 1'b0);
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  task automatic short_divisor_drain();
    logic [63:0] snap;
    send_cmd(CMD_DIVISOR, 56'd3);
    send_move(1'b0, 32'd200, 64'sd1 <<< 30, 0, snap);
    run_model(1'b0, 32'd200, 64'sd1 <<< 30, 0, 1'b1);
    wait_idle(1000, 1'b0);  // Far too short at divisor 40
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  task automatic half_step_mode();
    logic [63:0] snap;
    int          h0;
    h0 = hpos;
    send_cmd(CMD_STEP_MODE, 56'd1);
    half_mode = 1'b1;
    send_move(1'b1, 32'd16, STEP_THRESHOLD, 0, snap);
    run_model(1'b1, 32'd16, STEP_THRESHOLD, 0, 1'b1);
    wait_idle(1000, 1'b0);
    check_value("half step positions", 64'd16, 64'(hpos - h0));
    check_value("step_pos", exp_pos, 64'(step_pos));
  endtask

  initial begin
    rst_n = 1'b0;
    sck   = 1'b0;
    cs    = 1'b1;
    copi  = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    repeat (10) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    cycles(4);
    version_after_reset();
    constant_velocity_moves();
    accel_move();
    encoder_snapshot();
    disabled_coils();
    queue_backpressure();
    short_divisor_drain();
    half_step_mode();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: filelist.f
common/motion_pkg.sv
spi/spi_word_port.sv
verilog/command_sequencer.sv
verilog/move_queue.sv
dda/tick_divider.sv
dda/dda_step_engine.sv
verilog/quad_decoder.sv
verilog/hbridge_phaser.sv
verilog/motion_top.sv
verification/motion_checker.sv
verification/motion_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the motion controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module motion_tb -o motion_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/motion_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation returned an error status"
fi

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
